// ==== csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// csr address width, as seen on paddr
`define CSR_ADDR_W 12

// apb data bus width
`define CSR_DATA_W 32

// bits actually kept per register slot
`define CSR_STORE_W 12

// number of software visible slots
`define CSR_DEPTH 1024

// slot index, low address bits
`define CSR_INDEX_W 10

// width of cycle and instret counters
`define CSR_CNT_W 64

// risc-v user counter addresses
// low halves
`define CSR_CYCLE 12'hC00
`define CSR_INSTRET 12'hC02
// high halves
`define CSR_CYCLEH 12'hC80
`define CSR_INSTRETH 12'hC82

`endif

// ==== csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

	// full csr address from the host
	typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

	// one apb data word
	typedef logic [`CSR_DATA_W-1:0] csr_data_t;

	// what a slot really holds
	typedef logic [`CSR_STORE_W-1:0] csr_store_t;

	// slot number inside the store
	// addresses alias on the bits above this
	typedef logic [`CSR_INDEX_W-1:0] csr_index_t;

	// cycle / instret counter value
	typedef logic [`CSR_CNT_W-1:0] csr_cnt_t;

	// apb transfer phase
	// idle: psel low
	// setup: psel high, penable low
	// access: psel and penable high
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SETUP,
		PH_ACCESS
	} apb_phase_t;

endpackage : csr_pkg

// ==== csr_data.sv ====
`timescale 1ns/10ps

`include "csr_defines.svh"

module csr_data (
	input  logic               clk,
	input  logic               reset,

	// read side, straight from paddr
	input  csr_pkg::csr_addr_t rd_addr,
	output csr_pkg::csr_data_t rd_data,

	// write side, from the apb front end
	input  logic               wr_valid,
	input  csr_pkg::csr_addr_t wr_addr,
	input  csr_pkg::csr_data_t wr_data,

	// one pulse per retired instruction
	input  logic               retire_valid
);

	import csr_pkg::*;

	// register file, low 12 bits only
	csr_store_t slots [`CSR_DEPTH];

	// free running counters
	csr_cnt_t cycle_cnt;
	csr_cnt_t instret_cnt;

	// slot indices, upper two address bits dropped
	// so e.g. 0x005 and 0xc05 land in the same slot
	csr_index_t rd_idx;
	csr_index_t wr_idx;

	// counter address decode
	logic sel_cycle;
	logic sel_cycleh;
	logic sel_instret;
	logic sel_instreth;

	// slot value widened to the bus
	csr_data_t slot_word;

	assign rd_idx = rd_addr[`CSR_INDEX_W-1:0];
	assign wr_idx = wr_addr[`CSR_INDEX_W-1:0];

	// slot storage
	// write lands at the edge ending the apb access phase
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// every slot reads back zero after reset
			for (int i = 0; i < `CSR_DEPTH; i++) begin
				slots[i] <= '0;
			end
		end else if (wr_valid) begin
			// upper data bits are simply discarded
			slots[wr_idx] <= wr_data[`CSR_STORE_W-1:0];
		end
	end

	// cycle counter
	// counts every clock once reset is released
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + csr_cnt_t'(1);
		end
	end

	// retired instruction counter
	// one increment per cycle with retire_valid high
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			instret_cnt <= '0;
		end else if (retire_valid) begin
			instret_cnt <= instret_cnt + csr_cnt_t'(1);
		end
	end

	// exact match on the full 12 bit address
	// the counters shadow whatever slot shares their index
	assign sel_cycle    = (rd_addr == `CSR_CYCLE);
	assign sel_cycleh   = (rd_addr == `CSR_CYCLEH);
	assign sel_instret  = (rd_addr == `CSR_INSTRET);
	assign sel_instreth = (rd_addr == `CSR_INSTRETH);

	// zero extend the stored bits
	assign slot_word = {{(`CSR_DATA_W-`CSR_STORE_W){1'b0}}, slots[rd_idx]};

	// read mux, purely combinational
	// counters show the value held before the next edge
	always_comb begin
		if (sel_cycle) begin
			rd_data = cycle_cnt[`CSR_DATA_W-1:0];
		end else if (sel_cycleh) begin
			rd_data = cycle_cnt[`CSR_CNT_W-1:`CSR_DATA_W];
		end else if (sel_instret) begin
			rd_data = instret_cnt[`CSR_DATA_W-1:0];
		end else if (sel_instreth) begin
			rd_data = instret_cnt[`CSR_CNT_W-1:`CSR_DATA_W];
		end else begin
			rd_data = slot_word;
		end
	end

endmodule : csr_data

// ==== csr_apb_if.sv ====
`timescale 1ns/10ps

`include "csr_defines.svh"

module csr_apb_if (
	input  logic               clk,
	input  logic               reset,

	// apb slave side
	input  csr_pkg::csr_addr_t paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  csr_pkg::csr_data_t pwdata,
	output csr_pkg::csr_data_t prdata,
	output logic               pready,
	output logic               pslverr,

	// read data from the store, already decoded from paddr
	input  csr_pkg::csr_data_t rd_data,

	// write request into the store
	output logic               wr_valid,
	output csr_pkg::csr_addr_t wr_addr,
	output csr_pkg::csr_data_t wr_data
);

	import csr_pkg::*;

	// phase seen on the bus in the previous cycle
	apb_phase_t phase;

	// phase the host is driving right now
	apb_phase_t bus_phase;

	// access cycle that followed a proper setup cycle
	logic access;

	// top two address bits both set -> read only region
	logic ro_addr;

	// decode the current bus phase from psel / penable
	always_comb begin
		if (!psel) begin
			bus_phase = PH_IDLE;
		end else if (!penable) begin
			bus_phase = PH_SETUP;
		end else begin
			bus_phase = PH_ACCESS;
		end
	end

	// track the host
	// the fsm simply records where the bus was last cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= PH_IDLE;
		end else begin
			phase <= bus_phase;
		end
	end

	// access only counts right after setup
	// a host holding penable high gets no second completion
	assign access = (bus_phase == PH_ACCESS) && (phase == PH_SETUP);

	// no wait states, ready for the whole access cycle
	assign pready = access;

	// covers the counter addresses as well
	assign ro_addr = &paddr[`CSR_ADDR_W-1 -: 2];

	// writes to the read only region are refused
	// error instead of store write, never both
	assign pslverr  = access && pwrite && ro_addr;
	assign wr_valid = access && pwrite && !ro_addr;

	// address and data go through unchanged
	// store only acts on them when wr_valid is high
	assign wr_addr = paddr;
	assign wr_data = pwdata;

	// read data only during a read access, zero otherwise
	assign prdata = (access && !pwrite) ? rd_data : '0;

endmodule : csr_apb_if

// ==== csr_top.sv ====
`timescale 1ns/10ps

module csr_top (
	input  logic               clk,
	input  logic               reset,

	// apb from the host
	input  csr_pkg::csr_addr_t paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  csr_pkg::csr_data_t pwdata,
	output csr_pkg::csr_data_t prdata,
	output logic               pready,
	output logic               pslverr,

	// retire strobe from the core
	input  logic               retire_valid
);

	import csr_pkg::*;

	// store read result, routed back to the front end
	csr_data_t rd_data;

	// write request from front end to store
	logic      wr_valid;
	csr_addr_t wr_addr;
	csr_data_t wr_data;

	// apb slave, phase tracking and error response
	csr_apb_if u_apb (
		.clk      (clk),
		.reset    (reset),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.rd_data  (rd_data),
		.wr_valid (wr_valid),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	// register slots and counters
	// read side decodes paddr directly, no extra cycle
	csr_data u_data (
		.clk          (clk),
		.reset        (reset),
		.rd_addr      (paddr),
		.rd_data      (rd_data),
		.wr_valid     (wr_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.retire_valid (retire_valid)
	);

endmodule : csr_top

// ==== csr_props.sv ====
`timescale 1ns/10ps

`include "csr_defines.svh"

module csr_props (
	input logic               clk,
	input logic               reset,
	input csr_pkg::csr_addr_t paddr,
	input logic               psel,
	input logic               penable,
	input logic               pwrite,
	input logic               pready,
	input logic               pslverr,
	input logic               wr_valid
);

	// top two address bits set -> read only region
	logic ro_addr;

	assign ro_addr = &paddr[`CSR_ADDR_W-1 -: 2];

	// completion only inside a real access phase
	a_ready_in_access : assert property (
		@(posedge clk) disable iff (reset) pready |-> (psel && penable)
	) else $error("pready high outside an apb access phase");

	// error response is for refused writes only
	a_err_on_write : assert property (
		@(posedge clk) disable iff (reset) pslverr |-> pwrite
	) else $error("pslverr high during a read transfer");

	// read only region never reaches the store
	a_no_ro_store : assert property (
		@(posedge clk) disable iff (reset) wr_valid |-> !ro_addr
	) else $error("store write issued for a read-only address");

	// outputs quiet while reset is held
	a_quiet_in_reset : assert property (
		@(posedge clk) reset |-> (!pready && !pslverr && !wr_valid)
	) else $error("apb outputs active during reset");

endmodule : csr_props

// attach to every apb front end instance
bind csr_apb_if csr_props u_props (
	.clk      (clk),
	.reset    (reset),
	.paddr    (paddr),
	.psel     (psel),
	.penable  (penable),
	.pwrite   (pwrite),
	.pready   (pready),
	.pslverr  (pslverr),
	.wr_valid (wr_valid)
);

// ==== csr_tb.sv ====
`timescale 1ns/10ps

`include "csr_defines.svh"

module csr_tb;

	import csr_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 10;
	// transfers over all tests rounded up
	localparam int N_TRANSFERS   = 48;
	// two cycles per transfer plus idle slack
	localparam int MARGIN_CYCLES = 4;
	// retire pulse bursts over two rounds
	localparam int MAX_PULSES = 32;
	localparam int MAX_GAP    = 3;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_TRANSFERS * MARGIN_CYCLES
		+ MAX_PULSES * (MAX_GAP + 2);

	logic      clk;
	logic      reset;
	csr_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	csr_data_t pwdata;
	csr_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      retire_valid;

	// random stream state
	integer seed;

	csr_top u_dut (
		.clk          (clk),
		.reset        (reset),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.retire_valid (retire_valid)
	);

	// 20 ns clock
	always #(CLK_PERIOD / 2) clk = ~clk;

	// first mismatch ends the run
	task automatic check_value(input string name, input csr_data_t got, input csr_data_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// one setup + access pair
	// returns at the edge that completes it
	task automatic apb_transfer(
		input  csr_addr_t addr,
		input  logic      write,
		input  csr_data_t wdata,
		output csr_data_t rdata,
		output logic      err
	);
		@(negedge clk);
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		// no completion in the setup cycle
		#(CLK_PERIOD / 4);
		check_value("pready in setup", csr_data_t'(pready), 32'd0);
		@(negedge clk);
		penable = 1'b1;
		// sample mid access away from both edges
		#(CLK_PERIOD / 4);
		check_value("pready in access", csr_data_t'(pready), 32'd1);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
	endtask

	task automatic apb_write(input csr_addr_t addr, input csr_data_t data, output logic err);
		csr_data_t rdata;
		apb_transfer(addr, 1'b1, data, rdata, err);
		// no read data on a write
		check_value("prdata on write", rdata, 32'd0);
	endtask

	task automatic apb_read(input csr_addr_t addr, output csr_data_t data, output logic err);
		apb_transfer(addr, 1'b0, 32'd0, data, err);
	endtask

	// drop psel so the bus goes idle
	task automatic bus_idle();
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// slots and counters right after reset
	task automatic test_reset_values();
		csr_addr_t addrs [4] = '{12'h000, 12'h155, 12'h2aa, 12'h7ff};
		csr_data_t rd;
		logic      err;
		for (int i = 0; i < 4; i++) begin
			apb_read(addrs[i], rd, err);
			check_value("slot after reset", rd, 32'd0);
			check_value("pslverr on read", csr_data_t'(err), 32'd0);
		end
		// cycle already running so its value is open
		apb_read(`CSR_CYCLE, rd, err);
		check_value("pslverr on cycle read", csr_data_t'(err), 32'd0);
		apb_read(`CSR_CYCLEH, rd, err);
		check_value("cycleh after reset", rd, 32'd0);
		apb_read(`CSR_INSTRET, rd, err);
		check_value("instret after reset", rd, 32'd0);
		apb_read(`CSR_INSTRETH, rd, err);
		check_value("instreth after reset", rd, 32'd0);
	endtask

	// random word in and low 12 bits back
	task automatic test_write_read();
		csr_data_t rnd;
		csr_addr_t addr;
		csr_data_t wdata;
		csr_data_t rd;
		logic      err;
		for (int i = 0; i < 4; i++) begin
			rnd  = $random(seed);
			addr = rnd[11:0];
			// keep out of the read only region
			if (&addr[11:10]) begin
				addr[11] = 1'b0;
			end
			wdata = $random(seed);
			apb_write(addr, wdata, err);
			check_value("pslverr on rw write", csr_data_t'(err), 32'd0);
			apb_read(addr, rd, err);
			check_value("readback", rd, wdata & 32'h0000_0fff);
			check_value("pslverr on readback", csr_data_t'(err), 32'd0);
		end
	endtask

	// bits 11:10 ignored by the store
	task automatic test_alias();
		csr_data_t  rnd;
		csr_index_t idx;
		csr_data_t  v1;
		csr_data_t  v2;
		csr_data_t  rd;
		logic       err;
		rnd = $random(seed);
		// above the counter indices
		idx = 10'h100 | rnd[9:0];
		v1  = $random(seed);
		v2  = $random(seed);
		apb_write({2'b01, idx}, v1, err);
		apb_read({2'b10, idx}, rd, err);
		check_value("alias read", rd, v1 & 32'h0000_0fff);
		// read only alias still reads the slot
		apb_read({2'b11, idx}, rd, err);
		check_value("ro alias read", rd, v1 & 32'h0000_0fff);
		apb_write({2'b10, idx}, v2, err);
		apb_read({2'b01, idx}, rd, err);
		check_value("alias write back", rd, v2 & 32'h0000_0fff);
	endtask

	// refused writes leave the store alone
	task automatic test_read_only();
		csr_data_t  rnd;
		csr_index_t idx;
		csr_data_t  v1;
		csr_data_t  v2;
		csr_data_t  rd;
		logic       err;
		rnd = $random(seed);
		idx = 10'h100 | rnd[9:0];
		v1  = $random(seed);
		v2  = v1 ^ 32'h0000_0fff;
		apb_write({2'b00, idx}, v1, err);
		apb_write({2'b11, idx}, v2, err);
		check_value("pslverr on ro slot", csr_data_t'(err), 32'd1);
		apb_read({2'b00, idx}, rd, err);
		check_value("slot after ro write", rd, v1 & 32'h0000_0fff);
		// counter address shares slot 0
		apb_write(12'h000, v1, err);
		apb_write(`CSR_CYCLE, v2, err);
		check_value("pslverr on cycle write", csr_data_t'(err), 32'd1);
		apb_read(12'h000, rd, err);
		check_value("slot 0 after cycle write", rd, v1 & 32'h0000_0fff);
	endtask

	// completing edges two cycles apart
	task automatic test_cycle_count();
		csr_data_t c0;
		csr_data_t c1;
		logic      err;
		apb_read(`CSR_CYCLE, c0, err);
		apb_read(`CSR_CYCLE, c1, err);
		check_value("cycle delta", c1 - c0, 32'd2);
		apb_read(`CSR_CYCLEH, c0, err);
		check_value("cycleh", c0, 32'd0);
	endtask

	// pulse count vs instret delta
	task automatic test_retire_count();
		csr_data_t base;
		csr_data_t rd;
		csr_data_t n;
		csr_data_t gap;
		logic      err;
		for (int round = 0; round < 2; round++) begin
			apb_read(`CSR_INSTRET, base, err);
			bus_idle();
			n = ($random(seed) & 32'h0000_000f) + 32'd1;
			for (int i = 0; i < int'(n); i++) begin
				@(negedge clk);
				retire_valid = 1'b1;
				@(negedge clk);
				retire_valid = 1'b0;
				gap = $random(seed) & 32'h0000_0003;
				repeat (gap) @(negedge clk);
			end
			apb_read(`CSR_INSTRET, rd, err);
			check_value("instret delta", rd - base, n);
		end
		apb_read(`CSR_INSTRETH, rd, err);
		check_value("instreth", rd, 32'd0);
	endtask

	initial begin
		seed         = 32'ha52b;
		clk          = 1'b0;
		reset        = 1'b1;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		retire_valid = 1'b0;
		// host keeps writing through reset
		// alternating setup and access on a rw slot and a counter address
		for (int i = 0; i < RESET_CYCLES - 1; i++) begin
			@(negedge clk);
			psel    = 1'b1;
			penable = i[0];
			pwrite  = 1'b1;
			paddr   = i[1] ? `CSR_CYCLE : 12'h155;
			pwdata  = 32'hffff_ffff;
		end
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		reset   = 1'b0;
		test_reset_values();
		bus_idle();
		test_write_read();
		bus_idle();
		test_alias();
		bus_idle();
		test_read_only();
		bus_idle();
		test_cycle_count();
		bus_idle();
		test_retire_count();
		bus_idle();
		$display("*** TEST PASSED ***");
		$finish;
	end

	// run length bound
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, tests did not complete", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation timeout");
	end

endmodule : csr_tb

// ==== compile.f ====
+incdir+.
csr_pkg.sv
csr_data.sv
csr_apb_if.sv
csr_top.sv
csr_props.sv
csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the csr testbench with verilator
# the run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

# a failed build or a simulator error also counts as a failed test
verilator --binary --timing --assert -f compile.f --top-module csr_tb -Mdir obj_dir \
	&& ./obj_dir/Vcsr_tb > "$LOG" 2>&1 \
	|| echo "*** TEST FAILED ***" >> "$LOG"

cat "$LOG"

grep -qF "*** TEST FAILED ***" "$LOG" && { echo "simulation failed"; exit 1; }

echo "simulation passed"
exit 0
